//--- vlog.f
+incdir+include
src/wdpack_pkg.sv
src/wdpack_sram.sv
src/wdpack_data_fifo.sv
src/wdpack_packer.sv
src/wdpack_csr.sv
src/wdpack_top.sv
tb/tb_wdpack.sv

//--- tb/tb_wdpack.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the write-data packer. A model queue holds
// the expected wide beats, and these are compared as they leave the DUT.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "wdpack_params.svh"

module tb_wdpack;
  localparam int PAIR_BEATS  = 16;
  localparam int ODD_BEATS   = 7;
  localparam int PASS_BEATS  = 6;
  localparam int BP_BEATS    = 2 * (`WDPACK_FIFO_DEPTH + 1);
  localparam int CLEAR_FILL  = 7;
  localparam int CLEAR_AFTER = 6;
  localparam int TOTAL_BEATS = PAIR_BEATS + ODD_BEATS + PASS_BEATS + BP_BEATS
                               + CLEAR_FILL + CLEAR_AFTER;
  localparam int WATCHDOG_NS = TOTAL_BEATS * 20 * 10 + 1000;

  localparam wdpack_pkg::csr_addr_t CTRL   = wdpack_pkg::csr_addr_t'(0);
  localparam wdpack_pkg::csr_addr_t STATUS = wdpack_pkg::csr_addr_t'(1);
  localparam wdpack_pkg::csr_addr_t BEATS  = wdpack_pkg::csr_addr_t'(2);

  logic                       i_clk = 1'b0;
  logic                       i_reset;
  logic                       i_s_valid;
  wdpack_pkg::narrow_data_t   i_s_data;
  wdpack_pkg::narrow_byteen_t i_s_byteen;
  logic                       i_s_last;
  logic                       o_s_accept;
  logic                       o_m_valid;
  wdpack_pkg::wide_data_t     o_m_data;
  wdpack_pkg::wide_byteen_t   o_m_byteen;
  logic                       o_m_last;
  logic                       i_m_accept;
  logic                       i_csr_write;
  wdpack_pkg::csr_addr_t      i_csr_addr;
  wdpack_pkg::csr_data_t      i_csr_wdata;
  wdpack_pkg::csr_data_t      o_csr_rdata;

  // Expected wide beats, oldest first.
  wdpack_pkg::wide_data_t     exp_data[$];
  wdpack_pkg::wide_byteen_t   exp_byteen[$];
  logic                       exp_last[$];

  logic                       model_pack_enable;
  logic                       model_pending;
  wdpack_pkg::narrow_data_t   model_low_data;
  wdpack_pkg::narrow_byteen_t model_low_byteen;
  logic [31:0]                rng_state;
  int                         beats_since_clear;
  wdpack_pkg::wide_data_t     mon_data;
  wdpack_pkg::wide_byteen_t   mon_byteen;
  logic                       mon_last;

  wdpack_top UUT (
    .i_clk       (i_clk      ),
    .i_reset     (i_reset    ),
    .i_s_valid   (i_s_valid  ),
    .i_s_data    (i_s_data   ),
    .i_s_byteen  (i_s_byteen ),
    .i_s_last    (i_s_last   ),
    .o_s_accept  (o_s_accept ),
    .o_m_valid   (o_m_valid  ),
    .o_m_data    (o_m_data   ),
    .o_m_byteen  (o_m_byteen ),
    .o_m_last    (o_m_last   ),
    .i_m_accept  (i_m_accept ),
    .i_csr_write (i_csr_write),
    .i_csr_addr  (i_csr_addr ),
    .i_csr_wdata (i_csr_wdata),
    .o_csr_rdata (o_csr_rdata)
  );

  always #5 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  task automatic check_wide_data(input string name, input wdpack_pkg::wide_data_t exp,
                                 input wdpack_pkg::wide_data_t act);
    if (act !== exp) begin
      $display("Error: time %0t, %s expected %h, actual %h", $time, name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "wide data mismatch");
    end
  endtask

  task automatic check_wide_byteen(input string name, input wdpack_pkg::wide_byteen_t exp,
                                   input wdpack_pkg::wide_byteen_t act);
    if (act !== exp) begin
      $display("Error: time %0t, %s expected %h, actual %h", $time, name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "byte enable mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: time %0t, %s expected %b, actual %b", $time, name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_csr(input string name, input wdpack_pkg::csr_data_t exp,
                           input wdpack_pkg::csr_data_t act);
    if (act !== exp) begin
      $display("Error: time %0t, %s expected %h, actual %h", $time, name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "register mismatch");
    end
  endtask

  // Packing rule applied to each accepted narrow beat.
  task automatic model_narrow(input wdpack_pkg::narrow_data_t data,
                              input wdpack_pkg::narrow_byteen_t byteen, input logic last);
    if (model_pack_enable && model_pending) begin
      exp_data.push_back({data, model_low_data});
      exp_byteen.push_back({byteen, model_low_byteen});
      exp_last.push_back(last);
      model_pending = 1'b0;
    end else if (model_pack_enable && !last) begin
      model_low_data   = data;
      model_low_byteen = byteen;
      model_pending    = 1'b1;
    end else begin
      exp_data.push_back({32'h0, data});
      exp_byteen.push_back({4'h0, byteen});
      exp_last.push_back(last);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer.
  task automatic send_narrow(input wdpack_pkg::narrow_data_t data,
                             input wdpack_pkg::narrow_byteen_t byteen, input logic last);
    logic taken;
    taken      = 1'b0;
    i_s_valid  = 1'b1;
    i_s_data   = data;
    i_s_byteen = byteen;
    i_s_last   = last;
    while (!taken) begin
      taken = o_s_accept;
      @(negedge i_clk);
    end
    i_s_valid = 1'b0;
    model_narrow(data, byteen, last);
  endtask

  task automatic send_burst(input int n, input logic last_on_final);
    logic [31:0] data;
    logic [31:0] be;
    for (int i = 0; i < n; i++) begin
      data = next_random();
      be   = next_random();
      send_narrow(data, be[3:0], last_on_final && (i == n - 1));
    end
  endtask

  task automatic csr_write(input wdpack_pkg::csr_addr_t addr, input wdpack_pkg::csr_data_t data);
    i_csr_write = 1'b1;
    i_csr_addr  = addr;
    i_csr_wdata = data;
    @(negedge i_clk);
    i_csr_write = 1'b0;
  endtask

  task automatic csr_expect(input string name, input wdpack_pkg::csr_addr_t addr,
                            input wdpack_pkg::csr_data_t exp);
    i_csr_addr = addr;
    #1;
    check_csr(name, exp, o_csr_rdata);
    @(negedge i_clk);
  endtask

  // Drain the model queue, with accept either steady or random.
  task automatic drain(input logic random_accept);
    logic [31:0] r;
    while (exp_data.size() != 0) begin
      r          = next_random();
      i_m_accept = random_accept ? r[0] : 1'b1;
      @(negedge i_clk);
    end
    i_m_accept = 1'b1;
    repeat (4) @(negedge i_clk);
    check_bit("o_m_valid", 1'b0, o_m_valid);
  endtask

  task automatic after_reset();
    check_bit("o_m_valid", 1'b0, o_m_valid);
    check_bit("o_s_accept", 1'b1, o_s_accept);
    csr_expect("CTRL", CTRL, 32'h1);
    csr_expect("STATUS", STATUS, 32'h1);
    csr_expect("BEATS", BEATS, 32'h0);
  endtask

  task automatic pack_pairs();
    i_m_accept = 1'b1;
    send_burst(PAIR_BEATS, 1'b1);
    drain(1'b0);
  endtask

  task automatic odd_and_pass_through();
    send_burst(ODD_BEATS, 1'b1);
    drain(1'b0);
    csr_write(CTRL, 32'h0);
    model_pack_enable = 1'b0;
    csr_expect("CTRL", CTRL, 32'h0);
    send_burst(PASS_BEATS, 1'b1);
    drain(1'b0);
    csr_write(CTRL, 32'h1);
    model_pack_enable = 1'b1;
  endtask

  task automatic back_pressure();
    logic [31:0] data;
    i_m_accept = 1'b0;
    while (o_s_accept) begin
      data = next_random();
      send_narrow(data, 4'hf, 1'b0);
    end
    csr_expect("STATUS", STATUS, (32'(`WDPACK_FIFO_DEPTH) << 8) | 32'h2);
    drain(1'b1);
    csr_expect("BEATS", BEATS, 32'(beats_since_clear));
  endtask

  task automatic clear_mid_burst();
    i_m_accept = 1'b0;
    send_burst(CLEAR_FILL, 1'b0);
    // Let the first wide beat reach the output before clearing.
    while (!o_m_valid) begin
      @(negedge i_clk);
    end
    csr_write(CTRL, 32'h3);
    @(negedge i_clk);
    exp_data.delete();
    exp_byteen.delete();
    exp_last.delete();
    model_pending     = 1'b0;
    beats_since_clear = 0;
    check_bit("o_m_valid", 1'b0, o_m_valid);
    csr_expect("STATUS", STATUS, 32'h1);
    csr_expect("BEATS", BEATS, 32'h0);
    i_m_accept = 1'b1;
    send_burst(CLEAR_AFTER, 1'b1);
    drain(1'b0);
  endtask

  // Output compare against the model at each wide transfer.
  always @(posedge i_clk) begin
    if (!i_reset && o_m_valid && i_m_accept) begin
      if (exp_data.size() == 0) begin
        $display("Wide beat delivered at %0t while none was expected", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "extra wide beat");
      end else begin
        mon_data   = exp_data.pop_front();
        mon_byteen = exp_byteen.pop_front();
        mon_last   = exp_last.pop_front();
        check_wide_data("o_m_data", mon_data, o_m_data);
        check_wide_byteen("o_m_byteen", mon_byteen, o_m_byteen);
        check_bit("o_m_last", mon_last, o_m_last);
        beats_since_clear = beats_since_clear + 1;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    i_reset           = 1'b1;
    i_s_valid         = 1'b0;
    i_s_data          = '0;
    i_s_byteen        = '0;
    i_s_last          = 1'b0;
    i_m_accept        = 1'b0;
    i_csr_write       = 1'b0;
    i_csr_addr        = '0;
    i_csr_wdata       = '0;
    rng_state         = 32'hc116aa24;
    model_pack_enable = 1'b1;
    model_pending     = 1'b0;
    beats_since_clear = 0;
    repeat (2) @(negedge i_clk);
    i_reset = 1'b0;
    after_reset();
    pack_pairs();
    odd_and_pass_through();
    back_pressure();
    clear_mid_burst();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/wdpack_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write-data packer subsystem: narrow slave port in, wide master port
// out, with a CSR port for pack enable, clear and FIFO status.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module wdpack_top (
  input  var logic                        i_clk,
  input  var logic                        i_reset,
  input  var logic                        i_s_valid,
  input  var wdpack_pkg::narrow_data_t    i_s_data,
  input  var wdpack_pkg::narrow_byteen_t  i_s_byteen,
  input  var logic                        i_s_last,
  output var logic                        o_s_accept,
  output var logic                        o_m_valid,
  output var wdpack_pkg::wide_data_t      o_m_data,
  output var wdpack_pkg::wide_byteen_t    o_m_byteen,
  output var logic                        o_m_last,
  input  var logic                        i_m_accept,
  input  var logic                        i_csr_write,
  input  var wdpack_pkg::csr_addr_t       i_csr_addr,
  input  var wdpack_pkg::csr_data_t       i_csr_wdata,
  output var wdpack_pkg::csr_data_t       o_csr_rdata
);
  logic                      pack_enable;
  logic                      clear_pulse;
  logic                      w_valid;
  wdpack_pkg::wide_data_t    w_data;
  wdpack_pkg::wide_byteen_t  w_byteen;
  logic                      w_last;
  logic                      w_accept;
  logic                      fifo_completely_empty;
  logic                      fifo_full;
  wdpack_pkg::fifo_count_t   fifo_count;
  logic                      pop_done;

  assign pop_done = o_m_valid && i_m_accept;

  wdpack_csr u_csr (
    .i_clk                    (i_clk                  ),
    .i_reset                  (i_reset                ),
    .i_csr_write              (i_csr_write            ),
    .i_csr_addr               (i_csr_addr             ),
    .i_csr_wdata              (i_csr_wdata            ),
    .o_csr_rdata              (o_csr_rdata            ),
    .o_pack_enable            (pack_enable            ),
    .o_clear                  (clear_pulse            ),
    .i_fifo_completely_empty  (fifo_completely_empty  ),
    .i_fifo_full              (fifo_full              ),
    .i_fifo_count             (fifo_count             ),
    .i_pop_done               (pop_done               )
  );

  wdpack_packer u_packer (
    .i_clk          (i_clk        ),
    .i_reset        (i_reset      ),
    .i_clear        (clear_pulse  ),
    .i_pack_enable  (pack_enable  ),
    .i_s_valid      (i_s_valid    ),
    .i_s_data       (i_s_data     ),
    .i_s_byteen     (i_s_byteen   ),
    .i_s_last       (i_s_last     ),
    .o_s_accept     (o_s_accept   ),
    .o_w_valid      (w_valid      ),
    .o_w_data       (w_data       ),
    .o_w_byteen     (w_byteen     ),
    .o_w_last       (w_last       ),
    .i_w_accept     (w_accept     )
  );

  wdpack_data_fifo u_fifo (
    .i_clk              (i_clk                  ),
    .i_reset            (i_reset                ),
    .i_clear            (clear_pulse            ),
    .i_push             (w_valid                ),
    .i_push_data        (w_data                 ),
    .i_push_byteen      (w_byteen               ),
    .i_push_last        (w_last                 ),
    .o_push_accept      (w_accept               ),
    .o_pop_valid        (o_m_valid              ),
    .o_pop_data         (o_m_data               ),
    .o_pop_byteen       (o_m_byteen             ),
    .o_pop_last         (o_m_last               ),
    .i_pop_accept       (i_m_accept             ),
    .o_completely_empty (fifo_completely_empty  ),
    .o_full             (fifo_full              ),
    .o_count            (fifo_count             )
  );

endmodule

`default_nettype wire

//--- src/wdpack_csr.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control and status registers: pack enable, clear pulse, FIFO status
// and a count of wide beats popped. Reads decode combinationally.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module wdpack_csr (
  input  var logic                     i_clk,
  input  var logic                     i_reset,
  input  var logic                     i_csr_write,
  input  var wdpack_pkg::csr_addr_t    i_csr_addr,
  input  var wdpack_pkg::csr_data_t    i_csr_wdata,
  output var wdpack_pkg::csr_data_t    o_csr_rdata,
  output var logic                     o_pack_enable,
  output var logic                     o_clear,
  input  var logic                     i_fifo_completely_empty,
  input  var logic                     i_fifo_full,
  input  var wdpack_pkg::fifo_count_t  i_fifo_count,
  input  var logic                     i_pop_done
);
  localparam wdpack_pkg::csr_addr_t CTRL_ADDR   = wdpack_pkg::csr_addr_t'(0);
  localparam wdpack_pkg::csr_addr_t STATUS_ADDR = wdpack_pkg::csr_addr_t'(1);
  localparam wdpack_pkg::csr_addr_t BEATS_ADDR  = wdpack_pkg::csr_addr_t'(2);

  wdpack_pkg::csr_data_t beats;
  logic                  ctrl_write;

  assign ctrl_write = i_csr_write && (i_csr_addr == CTRL_ADDR);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_pack_enable <= 1'b1;
      o_clear       <= 1'b0;
      beats         <= '0;
    end else begin
      if (ctrl_write) begin
        o_pack_enable <= i_csr_wdata[0];
      end
      // Single-cycle pulse even on back-to-back writes.
      o_clear <= ctrl_write && i_csr_wdata[1] && !o_clear;
      if (o_clear) begin
        beats <= '0;
      end else if (i_pop_done) begin
        beats <= beats + wdpack_pkg::csr_data_t'(1);
      end
    end
  end

  always_comb begin
    o_csr_rdata = '0;
    case (i_csr_addr)
      CTRL_ADDR: begin
        o_csr_rdata[0] = o_pack_enable;
      end
      STATUS_ADDR: begin
        o_csr_rdata[0]                                       = i_fifo_completely_empty;
        o_csr_rdata[1]                                       = i_fifo_full;
        o_csr_rdata[8+:$bits(wdpack_pkg::fifo_count_t)]      = i_fifo_count;
      end
      BEATS_ADDR: begin
        o_csr_rdata = beats;
      end
      default: begin
        o_csr_rdata = '0;
      end
    endcase
  end

  assert property (@(posedge i_clk) disable iff (i_reset)
    o_clear |=> !o_clear);

endmodule

`default_nettype wire

//--- src/wdpack_packer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Merges pairs of narrow write-data beats into wide beats, or passes
// single beats through in the lower half when packing is disabled.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module wdpack_packer (
  input  var logic                        i_clk,
  input  var logic                        i_reset,
  input  var logic                        i_clear,
  input  var logic                        i_pack_enable,
  input  var logic                        i_s_valid,
  input  var wdpack_pkg::narrow_data_t    i_s_data,
  input  var wdpack_pkg::narrow_byteen_t  i_s_byteen,
  input  var logic                        i_s_last,
  output var logic                        o_s_accept,
  output var logic                        o_w_valid,
  output var wdpack_pkg::wide_data_t      o_w_data,
  output var wdpack_pkg::wide_byteen_t    o_w_byteen,
  output var logic                        o_w_last,
  input  var logic                        i_w_accept
);
  wdpack_pkg::pack_state_e    state;
  wdpack_pkg::narrow_data_t   low_data;
  wdpack_pkg::narrow_byteen_t low_byteen;
  wdpack_pkg::wide_data_t     next_data;
  wdpack_pkg::wide_byteen_t   next_byteen;
  logic                       s_fire;
  logic                       take_low;
  logic                       emit;

  // Output stage free now or draining this cycle.
  assign o_s_accept = !o_w_valid || i_w_accept;

  always_comb begin
    s_fire   = i_s_valid && o_s_accept;
    take_low = s_fire && i_pack_enable && (state == wdpack_pkg::PACK_LOW) && !i_s_last;
    emit     = s_fire && !take_low;
    if (state == wdpack_pkg::PACK_HIGH) begin
      next_data   = {i_s_data, low_data};
      next_byteen = {i_s_byteen, low_byteen};
    end else begin
      // Lone beat, upper half left empty.
      next_data   = {wdpack_pkg::narrow_data_t'('0), i_s_data};
      next_byteen = {wdpack_pkg::narrow_byteen_t'('0), i_s_byteen};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      state     <= wdpack_pkg::PACK_LOW;
      o_w_valid <= 1'b0;
    end else begin
      if (take_low) begin
        state <= wdpack_pkg::PACK_HIGH;
      end else if (emit) begin
        state <= wdpack_pkg::PACK_LOW;
      end

      if (emit) begin
        o_w_valid <= 1'b1;
      end else if (i_w_accept) begin
        o_w_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (take_low) begin
      low_data   <= i_s_data;
      low_byteen <= i_s_byteen;
    end
    if (emit) begin
      o_w_data   <= next_data;
      o_w_byteen <= next_byteen;
      o_w_last   <= i_s_last;
    end
  end

  // Software only turns packing off with no half pending.
  assert property (@(posedge i_clk) disable iff (i_reset)
    !i_pack_enable |-> (state == wdpack_pkg::PACK_LOW));

endmodule

`default_nettype wire

//--- src/wdpack_data_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wide-beat FIFO over the SRAM, with a prefetch register at the pop
// side. Push side takes the packer output, pop side is the wide port.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "wdpack_params.svh"

module wdpack_data_fifo (
  input  var logic                      i_clk,
  input  var logic                      i_reset,
  input  var logic                      i_clear,
  input  var logic                      i_push,
  input  var wdpack_pkg::wide_data_t    i_push_data,
  input  var wdpack_pkg::wide_byteen_t  i_push_byteen,
  input  var logic                      i_push_last,
  output var logic                      o_push_accept,
  output var logic                      o_pop_valid,
  output var wdpack_pkg::wide_data_t    o_pop_data,
  output var wdpack_pkg::wide_byteen_t  o_pop_byteen,
  output var logic                      o_pop_last,
  input  var logic                      i_pop_accept,
  output var logic                      o_completely_empty,
  output var logic                      o_full,
  output var wdpack_pkg::fifo_count_t   o_count
);
  localparam int DEPTH = `WDPACK_FIFO_DEPTH;
  localparam int WIDTH = `WDPACK_WIDE_WIDTH + `WDPACK_WIDE_WIDTH/8 + 1;

  wdpack_pkg::fifo_ptr_t   wr_ptr;
  wdpack_pkg::fifo_ptr_t   rd_ptr;
  wdpack_pkg::fifo_count_t sram_count;
  wdpack_pkg::fifo_count_t count;
  logic                    push;
  logic                    pop;
  logic                    sram_read;
  logic                    rd_valid;
  logic                    move;
  logic [WIDTH-1:0]        push_word;
  logic [WIDTH-1:0]        read_word;

  always_comb begin
    push      = i_push && o_push_accept;
    pop       = o_pop_valid && i_pop_accept;
    // SRAM read register is a second slot ahead of the output.
    move      = rd_valid && (!o_pop_valid || pop);
    sram_read = (sram_count != '0) && (!rd_valid || move);
    push_word = {i_push_data, i_push_byteen, i_push_last};
  end

  assign o_full             = (count == wdpack_pkg::fifo_count_t'(DEPTH));
  assign o_push_accept      = !o_full;
  assign o_completely_empty = (count == '0);
  assign o_count            = count;

  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      sram_count  <= '0;
      count       <= '0;
      rd_valid    <= 1'b0;
      o_pop_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + wdpack_pkg::fifo_ptr_t'(1);
      end
      if (sram_read) begin
        rd_ptr <= rd_ptr + wdpack_pkg::fifo_ptr_t'(1);
      end

      case ({push, sram_read})
        2'b10:   sram_count <= sram_count + wdpack_pkg::fifo_count_t'(1);
        2'b01:   sram_count <= sram_count - wdpack_pkg::fifo_count_t'(1);
        default: sram_count <= sram_count;
      endcase

      // Total occupancy, including entries past the SRAM.
      case ({push, pop})
        2'b10:   count <= count + wdpack_pkg::fifo_count_t'(1);
        2'b01:   count <= count - wdpack_pkg::fifo_count_t'(1);
        default: count <= count;
      endcase

      if (sram_read) begin
        rd_valid <= 1'b1;
      end else if (move) begin
        rd_valid <= 1'b0;
      end

      if (move) begin
        o_pop_valid <= 1'b1;
      end else if (pop) begin
        o_pop_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (move) begin
      {o_pop_data, o_pop_byteen, o_pop_last} <= read_word;
    end
  end

  wdpack_sram u_sram (
    .i_clk        (i_clk      ),
    .i_write      (push       ),
    .i_write_addr (wr_ptr     ),
    .i_write_data (push_word  ),
    .i_read       (sram_read  ),
    .i_read_addr  (rd_ptr     ),
    .o_read_data  (read_word  )
  );

  // SRAM write never lands on an entry not yet read.
  assert property (@(posedge i_clk) disable iff (i_reset || i_clear)
    push |-> (sram_count < wdpack_pkg::fifo_count_t'(DEPTH)));

  assert property (@(posedge i_clk) disable iff (i_reset)
    count <= wdpack_pkg::fifo_count_t'(DEPTH));

  assert property (@(posedge i_clk) disable iff (i_reset || i_clear)
    (o_pop_valid && !i_pop_accept) |=>
      (o_pop_valid && $stable({o_pop_data, o_pop_byteen, o_pop_last})));

endmodule

`default_nettype wire

//--- src/wdpack_sram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Simple dual-port memory for the wide-beat FIFO: one write port and
// one read port whose data is registered, so it arrives a cycle later.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "wdpack_params.svh"

module wdpack_sram (
  input  var logic                                             i_clk,
  input  var logic                                             i_write,
  input  var wdpack_pkg::fifo_ptr_t                            i_write_addr,
  input  var logic [`WDPACK_WIDE_WIDTH+`WDPACK_WIDE_WIDTH/8:0] i_write_data,
  input  var logic                                             i_read,
  input  var wdpack_pkg::fifo_ptr_t                            i_read_addr,
  output var logic [`WDPACK_WIDE_WIDTH+`WDPACK_WIDE_WIDTH/8:0] o_read_data
);
  localparam int DEPTH = `WDPACK_FIFO_DEPTH;
  localparam int WIDTH = `WDPACK_WIDE_WIDTH + `WDPACK_WIDE_WIDTH/8 + 1;

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_write) begin
      mem[i_write_addr] <= i_write_data;
    end
  end

  // Read data holds while no read is issued.
  always_ff @(posedge i_clk) begin
    if (i_read) begin
      o_read_data <= mem[i_read_addr];
    end
  end

endmodule

`default_nettype wire

//--- src/wdpack_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the packer, FIFO, CSR block and testbench.
// Refer to them by scoped name, e.g. wdpack_pkg::wide_data_t.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "wdpack_params.svh"

package wdpack_pkg;

  typedef logic [`WDPACK_NARROW_WIDTH-1:0]   narrow_data_t;
  typedef logic [`WDPACK_NARROW_WIDTH/8-1:0] narrow_byteen_t;
  typedef logic [`WDPACK_WIDE_WIDTH-1:0]     wide_data_t;
  typedef logic [`WDPACK_WIDE_WIDTH/8-1:0]   wide_byteen_t;

  typedef logic [$clog2(`WDPACK_FIFO_DEPTH)-1:0]   fifo_ptr_t;
  typedef logic [$clog2(`WDPACK_FIFO_DEPTH+1)-1:0] fifo_count_t;

  typedef logic [`WDPACK_CSR_ADDR_WIDTH-1:0] csr_addr_t;
  typedef logic [31:0]                       csr_data_t;

  // PACK_HIGH means a lower half is waiting for its partner.
  typedef enum logic {
    PACK_LOW  = 1'b0,
    PACK_HIGH = 1'b1
  } pack_state_e;

endpackage

`default_nettype wire

//--- include/wdpack_params.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes of the write-data packer. Include it wherever widths or the
// FIFO depth are needed; the package builds its types from these.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef WDPACK_PARAMS_SVH
`define WDPACK_PARAMS_SVH

// Narrow beat from the upstream master.
`define WDPACK_NARROW_WIDTH 32

// Wide beat, twice the narrow width.
`define WDPACK_WIDE_WIDTH 64

// Wide entries held in the SRAM, power of two.
`define WDPACK_FIFO_DEPTH 16

// CSR word address.
`define WDPACK_CSR_ADDR_WIDTH 2

`endif
